// File: src/game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// visible play area in pixels
`define SCREEN_W 1280
`define SCREEN_H 800

// moving block size
`define BLK_W 32
`define BLK_H 32

`define STEP 4 // pixels per accepted move

// where the block sits after reset
`define START_X 800
`define START_Y 400

// command queue depth and the credits the sender starts with
`define CMD_DEPTH 4

`define DESC_DEPTH   4 // descriptor queue entries
`define DESC_CREDITS 2 // renderer side buffer slots

`define N_OBS 4 // loadable obstacle slots

`endif

// File: src/game_pkg.sv
`include "game_cfg.svh"

package game_pkg;

  typedef logic [10:0] pos_x_t; // 0..1279
  typedef logic [9:0]  pos_y_t; // 0..799

  // bit index of each direction inside a mask
  localparam int DIR_UP    = 0;
  localparam int DIR_DOWN  = 1;
  localparam int DIR_LEFT  = 2;
  localparam int DIR_RIGHT = 3;

  typedef logic [3:0] dir_mask_t;

  typedef struct packed {
    dir_mask_t dir; // requested directions
  } move_cmd_t;

  // half open box with x0 <= x < x1 and y0 <= y < y1
  typedef struct packed {
    logic   en;
    pos_x_t x0;
    pos_y_t y0;
    pos_x_t x1;
    pos_y_t y1;
  } obs_rect_t;

  typedef struct packed {
    pos_x_t    x;
    pos_y_t    y;
    dir_mask_t blocked; // requested and refused
  } sprite_desc_t;

  // horizontal move where left wins over right
  function automatic pos_x_t step_x(pos_x_t x, dir_mask_t req, dir_mask_t blk);
    if (req[DIR_LEFT] && !blk[DIR_LEFT]) return x - pos_x_t'(`STEP);
    if (req[DIR_RIGHT] && !blk[DIR_RIGHT]) return x + pos_x_t'(`STEP);
    return x;
  endfunction

  // vertical move where up wins over down
  function automatic pos_y_t step_y(pos_y_t y, dir_mask_t req, dir_mask_t blk);
    if (req[DIR_UP] && !blk[DIR_UP]) return y - pos_y_t'(`STEP);
    if (req[DIR_DOWN] && !blk[DIR_DOWN]) return y + pos_y_t'(`STEP);
    return y;
  endfunction

endpackage

// File: src/obs_if.sv
`timescale 1ns/1ps

// collision query between the controller and the obstacle map
interface obs_if;

  logic                q_valid;   // one cycle query strobe
  game_pkg::pos_x_t    q_x;       // current block position
  game_pkg::pos_y_t    q_y;
  logic                r_valid;   // answer one cycle after q_valid
  game_pkg::dir_mask_t r_blocked; // directions that would collide

  modport ctrl (
    output q_valid,
    output q_x,
    output q_y,
    input  r_valid,
    input  r_blocked
  );

  modport map (
    input  q_valid,
    input  q_x,
    input  q_y,
    output r_valid,
    output r_blocked
  );

endinterface

// File: src/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk60hz,
  input  logic rst,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output T     o_data,
  output logic o_empty,
  output logic o_full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  // wrap at DEPTH since depth need not be a power of two
  function automatic logic [AW-1:0] bump(logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign o_data  = mem[rd_ptr]; // show-ahead head
  assign o_empty = (count == '0);
  assign o_full  = (count == CW'(DEPTH));

  always_ff @(posedge clk60hz) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk60hz) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= bump(wr_ptr);
      if (i_pop) rd_ptr <= bump(rd_ptr);
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  // the credit loops around the queue must keep these from happening
  a_no_overflow: assert property (@(posedge clk60hz) disable iff (rst)
    i_push |-> !o_full);

  a_no_underflow: assert property (@(posedge clk60hz) disable iff (rst)
    i_pop |-> !o_empty);

endmodule

// File: src/obstacle_map.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module obstacle_map (
  input  logic                       clk60hz,
  input  logic                       rst,
  input  logic                       i_obs_wr,
  input  logic [$clog2(`N_OBS)-1:0]  i_obs_idx,
  input  game_pkg::obs_rect_t        i_obs_rect,
  obs_if.map                         obs
);

  game_pkg::obs_rect_t rects [`N_OBS];
  int                  cand_x [4]; // block origin after each candidate move
  int                  cand_y [4];
  game_pkg::dir_mask_t edge_blk;   // leaves the screen
  game_pkg::dir_mask_t hit_blk;    // lands on an enabled obstacle

  // slot writes land on the next cycle
  always_ff @(posedge clk60hz) begin
    if (rst) begin
      for (int s = 0; s < `N_OBS; s++) begin
        rects[s] <= '0; // all disabled
      end
    end else if (i_obs_wr) begin
      rects[i_obs_idx] <= i_obs_rect;
    end
  end

  always_comb begin
    // signed shifted copies of the block so up/left may go negative
    cand_x[game_pkg::DIR_UP]    = int'(obs.q_x);
    cand_y[game_pkg::DIR_UP]    = int'(obs.q_y) - `STEP;
    cand_x[game_pkg::DIR_DOWN]  = int'(obs.q_x);
    cand_y[game_pkg::DIR_DOWN]  = int'(obs.q_y) + `STEP;
    cand_x[game_pkg::DIR_LEFT]  = int'(obs.q_x) - `STEP;
    cand_y[game_pkg::DIR_LEFT]  = int'(obs.q_y);
    cand_x[game_pkg::DIR_RIGHT] = int'(obs.q_x) + `STEP;
    cand_y[game_pkg::DIR_RIGHT] = int'(obs.q_y);

    edge_blk[game_pkg::DIR_UP]    = int'(obs.q_y) < `STEP;
    edge_blk[game_pkg::DIR_DOWN]  = int'(obs.q_y) + `STEP + `BLK_H > `SCREEN_H;
    edge_blk[game_pkg::DIR_LEFT]  = int'(obs.q_x) < `STEP;
    edge_blk[game_pkg::DIR_RIGHT] = int'(obs.q_x) + `STEP + `BLK_W > `SCREEN_W;

    hit_blk = '0;
    for (int d = 0; d < 4; d++) begin
      for (int s = 0; s < `N_OBS; s++) begin
        // overlap of two half open boxes on both axes
        if (rects[s].en &&
            cand_x[d] < int'(rects[s].x1) && int'(rects[s].x0) < cand_x[d] + `BLK_W &&
            cand_y[d] < int'(rects[s].y1) && int'(rects[s].y0) < cand_y[d] + `BLK_H) begin
          hit_blk[d] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk60hz) begin
    if (rst) obs.r_valid <= 1'b0;
    else     obs.r_valid <= obs.q_valid; // answer one cycle behind
  end

  always_ff @(posedge clk60hz) begin
    if (obs.q_valid) begin
      obs.r_blocked <= edge_blk | hit_blk;
    end
  end

endmodule

// File: src/pos_update.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module pos_update (
  input  logic                clk60hz,
  input  logic                rst,
  input  logic                i_apply,   // one pulse per command
  input  game_pkg::dir_mask_t i_req,
  input  game_pkg::dir_mask_t i_blocked,
  output game_pkg::pos_x_t    o_x,
  output game_pkg::pos_y_t    o_y
);

  game_pkg::pos_x_t blk_x;
  game_pkg::pos_y_t blk_y;

  // axes move independently and are both judged from the old position
  always_ff @(posedge clk60hz) begin
    if (rst) begin
      blk_x <= game_pkg::pos_x_t'(`START_X);
      blk_y <= game_pkg::pos_y_t'(`START_Y);
    end else if (i_apply) begin
      blk_x <= game_pkg::step_x(blk_x, i_req, i_blocked);
      blk_y <= game_pkg::step_y(blk_y, i_req, i_blocked);
    end
  end

  assign o_x = blk_x;
  assign o_y = blk_y;

  // relies on the edge test in the obstacle map
  a_on_screen: assert property (@(posedge clk60hz) disable iff (rst)
    (int'(blk_x) <= `SCREEN_W - `BLK_W) && (int'(blk_y) <= `SCREEN_H - `BLK_H));

endmodule

// File: src/move_ctrl.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module move_ctrl (
  input  logic                   clk60hz,
  input  logic                   rst,
  // command queue side
  input  logic                   i_cmd_empty,
  input  game_pkg::move_cmd_t    i_cmd,
  output logic                   o_cmd_pop,
  // collision query
  obs_if.ctrl                    obs,
  // position datapath
  input  game_pkg::pos_x_t       i_x,
  input  game_pkg::pos_y_t       i_y,
  output logic                   o_apply,
  output game_pkg::dir_mask_t    o_req,
  output game_pkg::dir_mask_t    o_blocked,
  // descriptor queue side
  output logic                   o_desc_push,
  output game_pkg::sprite_desc_t o_desc,
  input  logic                   i_desc_full,
  input  logic                   i_desc_empty,
  output logic                   o_desc_pop,
  input  logic                   i_desc_credit
);

  localparam int CW = $clog2(`DESC_CREDITS + 1);

  typedef enum logic [1:0] {
    IDLE,
    QUERY,
    WAIT,
    APPLY
  } state_t;

  state_t              state;
  game_pkg::dir_mask_t req_q; // latched request
  game_pkg::dir_mask_t blk_q; // latched collision answer
  logic [CW-1:0]       credit_cnt;

  // take a command only when its descriptor is sure to fit
  assign o_cmd_pop = (state == IDLE) && !i_cmd_empty && !i_desc_full;

  always_ff @(posedge clk60hz) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (o_cmd_pop) state <= QUERY;
        QUERY:   state <= WAIT;
        WAIT:    if (obs.r_valid) state <= APPLY;
        APPLY:   state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk60hz) begin
    if (o_cmd_pop) req_q <= i_cmd.dir;
    if (state == WAIT && obs.r_valid) blk_q <= obs.r_blocked;
  end

  // query at the position the block holds right now
  assign obs.q_valid = (state == QUERY);
  assign obs.q_x     = i_x;
  assign obs.q_y     = i_y;

  assign o_apply   = (state == APPLY);
  assign o_req     = req_q;
  assign o_blocked = req_q & blk_q; // only refused requests count

  // descriptor carries the position pos_update takes on this same edge
  assign o_desc_push = o_apply;
  assign o_desc = '{
    x:       game_pkg::step_x(i_x, req_q, blk_q),
    y:       game_pkg::step_y(i_y, req_q, blk_q),
    blocked: req_q & blk_q
  };

  // one downstream credit per renderer slot
  assign o_desc_pop = (credit_cnt != '0) && !i_desc_empty;

  always_ff @(posedge clk60hz) begin
    if (rst) begin
      credit_cnt <= CW'(`DESC_CREDITS);
    end else begin
      credit_cnt <= credit_cnt - CW'(o_desc_pop) + CW'(i_desc_credit);
    end
  end

  // renderer must not hand back more than it was given
  a_credit_max: assert property (@(posedge clk60hz) disable iff (rst)
    credit_cnt <= CW'(`DESC_CREDITS));

  // map answers every query exactly one cycle later
  a_query_answer: assert property (@(posedge clk60hz) disable iff (rst)
    obs.q_valid |=> obs.r_valid);

endmodule

// File: src/game_core.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module game_core (
  input  logic                      clk60hz,
  input  logic                      rst,
  // movement commands
  input  logic                      i_cmd_valid,
  input  game_pkg::dir_mask_t       i_cmd_dir,
  output logic                      o_cmd_credit,
  // obstacle slot load
  input  logic                      i_obs_wr,
  input  logic [$clog2(`N_OBS)-1:0] i_obs_idx,
  input  game_pkg::pos_x_t          i_obs_x0,
  input  game_pkg::pos_y_t          i_obs_y0,
  input  game_pkg::pos_x_t          i_obs_x1,
  input  game_pkg::pos_y_t          i_obs_y1,
  input  logic                      i_obs_en,
  // sprite descriptors to the renderer
  output logic                      o_desc_valid,
  output game_pkg::pos_x_t          o_desc_x,
  output game_pkg::pos_y_t          o_desc_y,
  output game_pkg::dir_mask_t       o_desc_blocked,
  input  logic                      i_desc_credit
);

  game_pkg::move_cmd_t    cmd_in;
  game_pkg::move_cmd_t    cmd_head;
  logic                   cmd_empty;
  logic                   cmd_pop;
  game_pkg::sprite_desc_t desc_in;
  game_pkg::sprite_desc_t desc_head;
  logic                   desc_push;
  logic                   desc_pop;
  logic                   desc_full;
  logic                   desc_empty;
  game_pkg::obs_rect_t    obs_rect;
  logic                   apply;
  game_pkg::dir_mask_t    req;
  game_pkg::dir_mask_t    blocked;
  game_pkg::pos_x_t       blk_x;
  game_pkg::pos_y_t       blk_y;

  obs_if obs_bus ();

  assign cmd_in   = '{dir: i_cmd_dir};
  assign obs_rect = '{en: i_obs_en, x0: i_obs_x0, y0: i_obs_y0, x1: i_obs_x1, y1: i_obs_y1};

  assign o_cmd_credit   = cmd_pop;  // every pop frees a sender slot
  assign o_desc_valid   = desc_pop; // every pop is a send
  assign o_desc_x       = desc_head.x;
  assign o_desc_y       = desc_head.y;
  assign o_desc_blocked = desc_head.blocked;

  // sender credits keep this one from filling, so full is left open
  credit_fifo #(
    .T     (game_pkg::move_cmd_t),
    .DEPTH (`CMD_DEPTH)
  ) u_cmd_fifo (
    .clk60hz (clk60hz),
    .rst     (rst),
    .i_push  (i_cmd_valid),
    .i_data  (cmd_in),
    .i_pop   (cmd_pop),
    .o_data  (cmd_head),
    .o_empty (cmd_empty),
    .o_full  ()
  );

  credit_fifo #(
    .T     (game_pkg::sprite_desc_t),
    .DEPTH (`DESC_DEPTH)
  ) u_desc_fifo (
    .clk60hz (clk60hz),
    .rst     (rst),
    .i_push  (desc_push),
    .i_data  (desc_in),
    .i_pop   (desc_pop),
    .o_data  (desc_head),
    .o_empty (desc_empty),
    .o_full  (desc_full)
  );

  obstacle_map u_obstacle_map (
    .clk60hz    (clk60hz),
    .rst        (rst),
    .i_obs_wr   (i_obs_wr),
    .i_obs_idx  (i_obs_idx),
    .i_obs_rect (obs_rect),
    .obs        (obs_bus.map)
  );

  pos_update u_pos_update (
    .clk60hz   (clk60hz),
    .rst       (rst),
    .i_apply   (apply),
    .i_req     (req),
    .i_blocked (blocked),
    .o_x       (blk_x),
    .o_y       (blk_y)
  );

  move_ctrl u_move_ctrl (
    .clk60hz       (clk60hz),
    .rst           (rst),
    .i_cmd_empty   (cmd_empty),
    .i_cmd         (cmd_head),
    .o_cmd_pop     (cmd_pop),
    .obs           (obs_bus.ctrl),
    .i_x           (blk_x),
    .i_y           (blk_y),
    .o_apply       (apply),
    .o_req         (req),
    .o_blocked     (blocked),
    .o_desc_push   (desc_push),
    .o_desc        (desc_in),
    .i_desc_full   (desc_full),
    .i_desc_empty  (desc_empty),
    .o_desc_pop    (desc_pop),
    .i_desc_credit (i_desc_credit)
  );

endmodule

// File: dv/tb_game_core.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module tb_game_core;

  localparam int N_EDGE  = 205; // enough up-left moves to reach both edges
  localparam int N_RAND  = 60;
  localparam int N_TOTAL = 1 + 3 + N_EDGE + 4 + N_RAND;
  localparam int LIMIT   = 20 * N_TOTAL + 200;

  logic                clk60hz;
  logic                rst;
  logic                i_cmd_valid;
  game_pkg::dir_mask_t i_cmd_dir;
  logic                o_cmd_credit;
  logic                i_obs_wr;
  logic [1:0]          i_obs_idx;
  game_pkg::pos_x_t    i_obs_x0;
  game_pkg::pos_y_t    i_obs_y0;
  game_pkg::pos_x_t    i_obs_x1;
  game_pkg::pos_y_t    i_obs_y1;
  logic                i_obs_en;
  logic                o_desc_valid;
  game_pkg::pos_x_t    o_desc_x;
  game_pkg::pos_y_t    o_desc_y;
  game_pkg::dir_mask_t o_desc_blocked;
  logic                i_desc_credit;

  // model state
  int  model_x;
  int  model_y;
  int  m_en [4];
  int  m_x0 [4];
  int  m_y0 [4];
  int  m_x1 [4];
  int  m_y1 [4];
  game_pkg::sprite_desc_t exp_q [$]; // expected descriptors in order
  game_pkg::sprite_desc_t head_d;

  // traffic counters each written by one process only
  int cmd_sent;
  int pops_seen;
  int desc_rcvd;
  int credits_back;
  int last_x;
  int last_y;
  int last_blk;

  int          rand_gaps;
  int          gap_tab [N_RAND];
  logic [31:0] rng;
  int          cycles;
  int          errors;
  int          test_errs;
  int          n_checks;
  int          n_tests;
  int          n_failed;

  game_core dut (.*);

  initial begin : clock_gen
    clk60hz = 1'b0;
    forever #50 clk60hz = ~clk60hz; // 100 ns frame tick
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // expected move for one command that returns the requested and blocked directions
  function automatic logic [3:0] ref_step(input int x, input int y, input logic [3:0] req,
                                          output int nx, output int ny);
    int         cx [4];
    int         cy [4];
    logic [3:0] blk;
    cx[0] = x; // up
    cy[0] = y - `STEP;
    cx[1] = x; // down
    cy[1] = y + `STEP;
    cx[2] = x - `STEP; // left
    cy[2] = y;
    cx[3] = x + `STEP; // right
    cy[3] = y;
    blk[0] = (y < `STEP);
    blk[1] = (y + `STEP + `BLK_H > `SCREEN_H);
    blk[2] = (x < `STEP);
    blk[3] = (x + `STEP + `BLK_W > `SCREEN_W);
    for (int d = 0; d < 4; d++) begin
      for (int s = 0; s < 4; s++) begin
        if (m_en[s] != 0 && cx[d] < m_x1[s] && m_x0[s] < cx[d] + `BLK_W &&
            cy[d] < m_y1[s] && m_y0[s] < cy[d] + `BLK_H) begin
          blk[d] = 1'b1;
        end
      end
    end
    nx = x;
    ny = y;
    if (req[0] && !blk[0]) ny = y - `STEP; // up before down
    else if (req[1] && !blk[1]) ny = y + `STEP;
    if (req[2] && !blk[2]) nx = x - `STEP; // left before right
    else if (req[3] && !blk[3]) nx = x + `STEP;
    return req & blk;
  endfunction

  task automatic check_eq(input int got, input int exp, input string what);
    n_checks++;
    if (got != exp) begin
      errors++;
      test_errs++;
      $display("Error at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      n_failed++;
      $display("test %s: failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // one command sent only while an upstream credit is held
  task automatic send_cmd(input logic [3:0] dir);
    int                     nx;
    int                     ny;
    logic [3:0]             blk;
    game_pkg::sprite_desc_t exp_d;
    while (cmd_sent - pops_seen >= `CMD_DEPTH) @(negedge clk60hz);
    blk = ref_step(model_x, model_y, dir, nx, ny);
    exp_d.x       = game_pkg::pos_x_t'(nx);
    exp_d.y       = game_pkg::pos_y_t'(ny);
    exp_d.blocked = blk;
    exp_q.push_back(exp_d);
    model_x = nx;
    model_y = ny;
    i_cmd_valid = 1'b1;
    i_cmd_dir   = dir;
    cmd_sent++;
    @(negedge clk60hz);
    i_cmd_valid = 1'b0;
    i_cmd_dir   = '0;
  endtask

  task automatic load_obs(input int idx, input int x0, input int y0, input int x1,
                          input int y1, input int en);
    m_en[idx] = en;
    m_x0[idx] = x0;
    m_y0[idx] = y0;
    m_x1[idx] = x1;
    m_y1[idx] = y1;
    i_obs_wr  = 1'b1;
    i_obs_idx = 2'(idx);
    i_obs_x0  = game_pkg::pos_x_t'(x0);
    i_obs_y0  = game_pkg::pos_y_t'(y0);
    i_obs_x1  = game_pkg::pos_x_t'(x1);
    i_obs_y1  = game_pkg::pos_y_t'(y1);
    i_obs_en  = (en != 0);
    @(negedge clk60hz);
    i_obs_wr = 1'b0;
  endtask

  // all expected descriptors seen and every credit handed back
  task automatic wait_drain();
    while (exp_q.size() != 0 || credits_back != desc_rcvd) @(negedge clk60hz);
    @(negedge clk60hz);
  endtask

  // renderer side returning one credit per received descriptor
  initial begin : credit_return
    int gap;
    gap = 0;
    forever begin
      @(negedge clk60hz);
      i_desc_credit = 1'b0;
      if (desc_rcvd > credits_back) begin
        if (gap > 0) begin
          gap--;
        end else begin
          i_desc_credit = 1'b1;
          credits_back++;
          if (rand_gaps != 0) gap = gap_tab[credits_back % N_RAND];
        end
      end
    end
  end

  // compare every sent descriptor against the expected queue
  initial begin : monitor
    forever begin
      @(posedge clk60hz);
      if (!rst) begin
        if (o_cmd_credit) begin
          pops_seen++;
          check_eq(int'(pops_seen <= cmd_sent), 1, "credit pulse without a command");
        end
        if (o_desc_valid) begin
          desc_rcvd++;
          check_eq(int'(desc_rcvd - credits_back <= `DESC_CREDITS), 1,
                   "descriptors outstanding beyond credits");
          if (exp_q.size() == 0) begin
            check_eq(0, 1, "descriptor with none expected");
          end else begin
            head_d = exp_q.pop_front();
            check_eq(int'(o_desc_x), int'(head_d.x), "descriptor x");
            check_eq(int'(o_desc_y), int'(head_d.y), "descriptor y");
            check_eq(int'(o_desc_blocked), int'(head_d.blocked), "descriptor blocked");
          end
          last_x   = int'(o_desc_x);
          last_y   = int'(o_desc_y);
          last_blk = int'(o_desc_blocked);
        end
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk60hz);
      cycles++;
    end
    $display("run stopped after %0d cycles, descriptors still missing", cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    rst = 1'b1;
    i_cmd_valid = 1'b0;
    i_cmd_dir = '0;
    i_obs_wr = 1'b0;
    i_obs_idx = '0;
    i_obs_x0 = '0;
    i_obs_y0 = '0;
    i_obs_x1 = '0;
    i_obs_y1 = '0;
    i_obs_en = 1'b0;
    i_desc_credit = 1'b0;
    model_x = `START_X;
    model_y = `START_Y;
    for (int s = 0; s < 4; s++) begin
      m_en[s] = 0;
      m_x0[s] = 0;
      m_y0[s] = 0;
      m_x1[s] = 0;
      m_y1[s] = 0;
    end
    cmd_sent = 0;
    pops_seen = 0;
    desc_rcvd = 0;
    credits_back = 0;
    errors = 0;
    test_errs = 0;
    n_checks = 0;
    n_tests = 0;
    n_failed = 0;
    rand_gaps = 0;
    rng = 32'hf5b38517;
    repeat (2) @(posedge clk60hz); // two cycles in reset
    @(negedge clk60hz);
    rst = 1'b0;

    // reset state
    repeat (4) begin
      check_eq(int'(o_desc_valid), 0, "o_desc_valid idle after reset");
      check_eq(int'(o_cmd_credit), 0, "o_cmd_credit idle after reset");
      @(negedge clk60hz);
    end
    send_cmd(4'b0000);
    wait_drain();
    check_eq(last_x, `START_X, "start x");
    check_eq(last_y, `START_Y, "start y");
    check_eq(last_blk, 0, "start blocked");
    end_test("reset_state");

    // opposite pairs resolve to up and left
    send_cmd(4'b0011);
    send_cmd(4'b1100);
    send_cmd(4'b1111);
    wait_drain();
    check_eq(last_x, `START_X - 2 * `STEP, "x after priority moves");
    check_eq(last_y, `START_Y - 2 * `STEP, "y after priority moves");
    end_test("priority");

    for (int i = 0; i < N_EDGE; i++) send_cmd(4'b0101);
    wait_drain();
    check_eq(last_x, 0, "x at left edge");
    check_eq(last_y, 0, "y at top edge");
    check_eq(last_blk, 4'b0101, "edge blocked bits");
    end_test("screen_edges");

    // wall just right of the block at the top left corner
    load_obs(1, 34, 0, 80, 32, 1);
    send_cmd(4'b1000);
    send_cmd(4'b0010);
    send_cmd(4'b0001);
    wait_drain();
    check_eq(last_y, 0, "back at top after down and up");
    load_obs(1, 34, 0, 80, 32, 0); // slot disabled
    send_cmd(4'b1000);
    wait_drain();
    check_eq(last_x, `STEP, "right move after disable");
    check_eq(last_blk, 0, "nothing blocked after disable");
    end_test("obstacles");

    // random burst with random credit gaps
    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift(rng);
      gap_tab[i] = int'(rng[10:8]);
    end
    rand_gaps = 1;
    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift(rng);
      send_cmd(rng[3:0]);
    end
    wait_drain();
    check_eq(pops_seen, cmd_sent, "credit pulses per command");
    check_eq(desc_rcvd, cmd_sent, "descriptors per command");
    end_test("back_pressure");

    $display("tests %0d, failed %0d, checks %0d, errors %0d, cycles %0d",
             n_tests, n_failed, n_checks, errors, cycles);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/game_pkg.sv
src/obs_if.sv
src/credit_fifo.sv
src/obstacle_map.sv
src/pos_update.sv
src/move_ctrl.sv
src/game_core.sv
dv/tb_game_core.sv

// File: Makefile
VERILATOR = verilator
TOP       = tb_game_core
FILELIST  = compile.f
OBJ_DIR   = obj_dir
FLAGS     = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# the simulation output is searched for the pass line, grep sets the status
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
